// ==== rtl/bp_mem_bridge_pkg.sv ====
/*
  Memory bridge package
  Message format, link widths, memory geometry and address map
*/
`default_nettype none

package bp_mem_bridge_pkg;

  localparam int flit_width_lp  = 32;
  localparam int paddr_width_lp = 32;
  localparam int dword_width_lp = 64;

  typedef enum logic [1:0] {
    e_mem_rd = 2'b00,
    e_mem_wr = 2'b01
  } bp_mem_opcode_e;

  // Data sits in the low bits, so flit 0 carries data[31:0]
  typedef struct packed {
    bp_mem_opcode_e            opcode;
    logic [paddr_width_lp-1:0] addr;
    logic [dword_width_lp-1:0] data;
  } bp_mem_msg_s;

  localparam int msg_width_lp      = $bits(bp_mem_msg_s);
  localparam int msg_flits_lp      = (msg_width_lp + flit_width_lp - 1) / flit_width_lp;
  localparam int flit_cnt_width_lp = $clog2(msg_flits_lp);

  // Address map
  localparam logic [paddr_width_lp-1:0] mem_base_lp         = 32'h8000_0000;
  localparam logic [paddr_width_lp-1:0] host_finish_addr_lp = 32'h0010_0000;

  localparam int mem_els_lp        = 256;
  localparam int mem_idx_width_lp  = $clog2(mem_els_lp);
  localparam int max_latency_lp    = 4;
  localparam int latency_width_lp  = $clog2(max_latency_lp);

endpackage

`default_nettype wire

// ==== rtl/bp_bypass_sipo.sv ====
/*
  Bypass link deserializer
  Collects command flits into one message and holds it until taken
*/
`timescale 1ns/1ns
`default_nettype none

module bp_bypass_sipo (
  input  logic                                      clk_i,
  input  logic                                      rst_i,

  input  logic [bp_mem_bridge_pkg::flit_width_lp-1:0] flit_i,
  input  logic                                      v_i,
  output logic                                      ready_o,

  output bp_mem_bridge_pkg::bp_mem_msg_s            msg_o,
  output logic                                      v_o,
  input  logic                                      yumi_i
);

  import bp_mem_bridge_pkg::*;

  logic [msg_flits_lp*flit_width_lp-1:0] data_r;
  logic [flit_cnt_width_lp-1:0]          cnt_r;
  logic                                  full_r;
  logic                                  flit_take;

  assign ready_o   = ~full_r;
  assign flit_take = v_i & ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_r  <= '0;
      full_r <= 1'b0;
    end else begin
      if (flit_take) begin
        if (cnt_r == flit_cnt_width_lp'(msg_flits_lp - 1)) begin
          cnt_r  <= '0;
          full_r <= 1'b1;
        end else begin
          cnt_r <= cnt_r + 1'b1;
        end
      end else if (yumi_i) begin
        full_r <= 1'b0;
      end
    end
  end

  // Lowest flit lands in the lowest slot
  always_ff @(posedge clk_i) begin
    if (flit_take) begin
      data_r[cnt_r*flit_width_lp +: flit_width_lp] <= flit_i;
    end
  end

  assign msg_o = data_r[msg_width_lp-1:0];
  assign v_o   = full_r;

endmodule

`default_nettype wire

// ==== rtl/bp_bypass_piso.sv ====
/*
  Bypass link serializer
  Latches one response message and sends it as flits, lowest first
*/
`timescale 1ns/1ns
`default_nettype none

module bp_bypass_piso (
  input  logic                                        clk_i,
  input  logic                                        rst_i,

  input  bp_mem_bridge_pkg::bp_mem_msg_s              msg_i,
  input  logic                                        v_i,
  output logic                                        ready_o,

  output logic [bp_mem_bridge_pkg::flit_width_lp-1:0] flit_o,
  output logic                                        v_o,
  input  logic                                        ready_and_i
);

  import bp_mem_bridge_pkg::*;

  logic [msg_flits_lp*flit_width_lp-1:0] data_r;
  logic [flit_cnt_width_lp-1:0]          cnt_r;
  logic                                  busy_r;
  logic                                  msg_take;
  logic                                  flit_sent;

  assign ready_o   = ~busy_r;
  assign msg_take  = v_i & ready_o;
  assign flit_sent = v_o & ready_and_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_r  <= '0;
      busy_r <= 1'b0;
    end else if (msg_take) begin
      cnt_r  <= '0;
      busy_r <= 1'b1;
    end else if (flit_sent) begin
      if (cnt_r == flit_cnt_width_lp'(msg_flits_lp - 1)) begin
        busy_r <= 1'b0;
      end
      cnt_r <= cnt_r + 1'b1;
    end
  end

  // Upper pad bits go out as zero
  always_ff @(posedge clk_i) begin
    if (msg_take) begin
      data_r <= (msg_flits_lp*flit_width_lp)'(msg_i);
    end
  end

  // Current flit stays put until the link takes it
  assign flit_o = data_r[cnt_r*flit_width_lp +: flit_width_lp];
  assign v_o    = busy_r;

endmodule

`default_nettype wire

// ==== rtl/bp_io_router.sv ====
/*
  Command router and response merge
  Steers commands to memory or host by address, merges the replies
*/
`timescale 1ns/1ns
`default_nettype none

module bp_io_router (
  input  bp_mem_bridge_pkg::bp_mem_msg_s  cmd_i,
  input  logic                            cmd_v_i,
  output logic                            cmd_yumi_o,

  output bp_mem_bridge_pkg::bp_mem_msg_s  mem_cmd_o,
  output logic                            mem_cmd_v_o,
  input  logic                            mem_cmd_yumi_i,

  output bp_mem_bridge_pkg::bp_mem_msg_s  host_cmd_o,
  output logic                            host_cmd_v_o,
  input  logic                            host_cmd_yumi_i,

  input  bp_mem_bridge_pkg::bp_mem_msg_s  mem_resp_i,
  input  logic                            mem_resp_v_i,
  output logic                            mem_resp_ready_o,

  input  bp_mem_bridge_pkg::bp_mem_msg_s  host_resp_i,
  input  logic                            host_resp_v_i,
  output logic                            host_resp_ready_o,

  output bp_mem_bridge_pkg::bp_mem_msg_s  resp_o,
  output logic                            resp_v_o,
  input  logic                            resp_ready_i
);

  import bp_mem_bridge_pkg::*;

  logic to_mem;

  // Anything in the upper half is memory
  assign to_mem = (cmd_i.addr & mem_base_lp) == mem_base_lp;

  assign mem_cmd_o    = cmd_i;
  assign host_cmd_o   = cmd_i;
  assign mem_cmd_v_o  = cmd_v_i & to_mem;
  assign host_cmd_v_o = cmd_v_i & ~to_mem;

  // Selected target's yumi passes straight back
  assign cmd_yumi_o = to_mem ? mem_cmd_yumi_i : host_cmd_yumi_i;

  // Fixed priority, memory first
  assign resp_o   = mem_resp_v_i ? mem_resp_i : host_resp_i;
  assign resp_v_o = mem_resp_v_i | host_resp_v_i;

  assign mem_resp_ready_o  = resp_ready_i;
  assign host_resp_ready_o = resp_ready_i & ~mem_resp_v_i;

endmodule

`default_nettype wire

// ==== rtl/bp_mem_model.sv ====
/*
  Dword memory model
  One command at a time, response after a pseudo-random 1 to 4 cycles
*/
`timescale 1ns/1ns
`default_nettype none

module bp_mem_model (
  input  logic                            clk_i,
  input  logic                            rst_i,

  input  bp_mem_bridge_pkg::bp_mem_msg_s  cmd_i,
  input  logic                            cmd_v_i,
  output logic                            cmd_yumi_o,

  output bp_mem_bridge_pkg::bp_mem_msg_s  resp_o,
  output logic                            resp_v_o,
  input  logic                            resp_ready_i
);

  import bp_mem_bridge_pkg::*;

  logic [dword_width_lp-1:0]   mem_r [mem_els_lp];
  logic [mem_idx_width_lp-1:0] cmd_idx;
  logic [latency_width_lp-1:0] lat_r;
  logic [7:0]                  lfsr_r;
  logic                        busy_r;
  bp_mem_msg_s                 resp_r;
  logic                        resp_done;

  assign cmd_idx    = cmd_i.addr[3 +: mem_idx_width_lp];
  assign cmd_yumi_o = cmd_v_i & ~busy_r;
  assign resp_done  = resp_v_o & resp_ready_i;

  // x^8 + x^6 + x^5 + x^4 + 1, free running
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lfsr_r <= 8'h01;
    end else begin
      lfsr_r <= {lfsr_r[6:0], lfsr_r[7] ^ lfsr_r[5] ^ lfsr_r[4] ^ lfsr_r[3]};
    end
  end

  // Busy from accept until the response is taken
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_r <= 1'b0;
      lat_r  <= '0;
    end else if (cmd_yumi_o) begin
      busy_r <= 1'b1;
      lat_r  <= lfsr_r[latency_width_lp-1:0];
    end else if (busy_r) begin
      if (lat_r != '0) begin
        lat_r <= lat_r - 1'b1;
      end else if (resp_done) begin
        busy_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_yumi_o && cmd_i.opcode == e_mem_wr) begin
      mem_r[cmd_idx] <= cmd_i.data;
    end
  end

  // Reply is built at accept time, writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (cmd_yumi_o) begin
      resp_r.opcode <= cmd_i.opcode;
      resp_r.addr   <= cmd_i.addr;
      if (cmd_i.opcode == e_mem_rd) begin
        resp_r.data <= mem_r[cmd_idx];
      end else begin
        resp_r.data <= '0;
      end
    end
  end

  assign resp_o   = resp_r;
  assign resp_v_o = busy_r & (lat_r == '0);

endmodule

`default_nettype wire

// ==== rtl/bp_host_mmio.sv ====
/*
  Host MMIO endpoint
  Holds the program-finish flag and answers every host access
*/
`timescale 1ns/1ns
`default_nettype none

module bp_host_mmio (
  input  logic                            clk_i,
  input  logic                            rst_i,

  input  bp_mem_bridge_pkg::bp_mem_msg_s  cmd_i,
  input  logic                            cmd_v_i,
  output logic                            cmd_yumi_o,

  output bp_mem_bridge_pkg::bp_mem_msg_s  resp_o,
  output logic                            resp_v_o,
  input  logic                            resp_ready_i,

  output logic                            program_finish_o
);

  import bp_mem_bridge_pkg::*;

  logic        resp_v_r;
  logic        finish_r;
  logic        hit_finish;
  bp_mem_msg_s resp_r;

  assign hit_finish = cmd_i.addr == host_finish_addr_lp;
  assign cmd_yumi_o = cmd_v_i & ~resp_v_r;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      resp_v_r <= 1'b0;
      finish_r <= 1'b0;
    end else begin
      if (cmd_yumi_o) begin
        resp_v_r <= 1'b1;
      end else if (resp_ready_i) begin
        resp_v_r <= 1'b0;
      end
      if (cmd_yumi_o && hit_finish && cmd_i.opcode == e_mem_wr) begin
        finish_r <= cmd_i.data[0];
      end
    end
  end

  // Unmapped reads and all writes return zero data
  always_ff @(posedge clk_i) begin
    if (cmd_yumi_o) begin
      resp_r.opcode <= cmd_i.opcode;
      resp_r.addr   <= cmd_i.addr;
      resp_r.data   <= '0;
      if (hit_finish && cmd_i.opcode == e_mem_rd) begin
        resp_r.data[0] <= finish_r;
      end
    end
  end

  assign resp_o           = resp_r;
  assign resp_v_o         = resp_v_r;
  assign program_finish_o = finish_r;

endmodule

`default_nettype wire

// ==== rtl/bp_mem_bridge_top.sv ====
/*
  Memory bridge top level
  Bypass link in, memory and host MMIO behind a router, bypass link out
*/
`timescale 1ns/1ns
`default_nettype none

module bp_mem_bridge_top (
  input  logic                                        clk_i,
  input  logic                                        rst_i,

  input  logic [bp_mem_bridge_pkg::flit_width_lp-1:0] cmd_flit_i,
  input  logic                                        cmd_v_i,
  output logic                                        cmd_ready_o,

  output logic [bp_mem_bridge_pkg::flit_width_lp-1:0] resp_flit_o,
  output logic                                        resp_v_o,
  input  logic                                        resp_ready_i,

  output logic                                        program_finish_o
);

  import bp_mem_bridge_pkg::*;

  bp_mem_msg_s cmd_msg, resp_msg;
  logic        cmd_msg_v, cmd_msg_yumi;
  logic        resp_msg_v, resp_msg_ready;

  bp_mem_msg_s mem_cmd, mem_resp;
  logic        mem_cmd_v, mem_cmd_yumi, mem_resp_v, mem_resp_ready;

  bp_mem_msg_s host_cmd, host_resp;
  logic        host_cmd_v, host_cmd_yumi, host_resp_v, host_resp_ready;

  bp_bypass_sipo cmd_sipo (
    .clk_i(clk_i), .rst_i(rst_i),
    .flit_i(cmd_flit_i), .v_i(cmd_v_i), .ready_o(cmd_ready_o),
    .msg_o(cmd_msg), .v_o(cmd_msg_v), .yumi_i(cmd_msg_yumi)
  );

  bp_io_router router (
    .cmd_i(cmd_msg), .cmd_v_i(cmd_msg_v), .cmd_yumi_o(cmd_msg_yumi),
    .mem_cmd_o(mem_cmd), .mem_cmd_v_o(mem_cmd_v), .mem_cmd_yumi_i(mem_cmd_yumi),
    .host_cmd_o(host_cmd), .host_cmd_v_o(host_cmd_v), .host_cmd_yumi_i(host_cmd_yumi),
    .mem_resp_i(mem_resp), .mem_resp_v_i(mem_resp_v), .mem_resp_ready_o(mem_resp_ready),
    .host_resp_i(host_resp), .host_resp_v_i(host_resp_v),
    .host_resp_ready_o(host_resp_ready),
    .resp_o(resp_msg), .resp_v_o(resp_msg_v), .resp_ready_i(resp_msg_ready)
  );

  bp_mem_model mem (
    .clk_i(clk_i), .rst_i(rst_i),
    .cmd_i(mem_cmd), .cmd_v_i(mem_cmd_v), .cmd_yumi_o(mem_cmd_yumi),
    .resp_o(mem_resp), .resp_v_o(mem_resp_v), .resp_ready_i(mem_resp_ready)
  );

  bp_host_mmio host_mmio (
    .clk_i(clk_i), .rst_i(rst_i),
    .cmd_i(host_cmd), .cmd_v_i(host_cmd_v), .cmd_yumi_o(host_cmd_yumi),
    .resp_o(host_resp), .resp_v_o(host_resp_v), .resp_ready_i(host_resp_ready),
    .program_finish_o(program_finish_o)
  );

  bp_bypass_piso resp_piso (
    .clk_i(clk_i), .rst_i(rst_i),
    .msg_i(resp_msg), .v_i(resp_msg_v), .ready_o(resp_msg_ready),
    .flit_o(resp_flit_o), .v_o(resp_v_o), .ready_and_i(resp_ready_i)
  );

endmodule

`default_nettype wire

// ==== dv/bp_mem_bridge_chk.sv ====
/*
  Memory bridge protocol checker
  Link stability, router yumi and target response hold
*/
`timescale 1ns/1ns
`default_nettype none

module bp_mem_bridge_chk (
  input logic                                        clk_i,
  input logic                                        rst_i,
  input logic [bp_mem_bridge_pkg::flit_width_lp-1:0] cmd_flit_i,
  input logic                                        cmd_v_i,
  input logic                                        cmd_ready_i,
  input logic [bp_mem_bridge_pkg::flit_width_lp-1:0] resp_flit_i,
  input logic                                        resp_v_i,
  input logic                                        resp_ready_i,
  input logic                                        cmd_msg_v_i,
  input logic                                        cmd_msg_yumi_i,
  input logic                                        mem_resp_v_i,
  input logic                                        mem_resp_ready_i,
  input logic                                        host_resp_v_i,
  input logic                                        host_resp_ready_i
);

  cmd_link_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    cmd_v_i && !cmd_ready_i |=> cmd_v_i && $stable(cmd_flit_i))
    else $error("command flit or valid changed while stalled");

  resp_link_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    resp_v_i && !resp_ready_i |=> resp_v_i && $stable(resp_flit_i))
    else $error("response flit or valid changed while stalled");

  yumi_needs_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    cmd_msg_yumi_i |-> cmd_msg_v_i)
    else $error("router yumi without a valid command");

  // Target responses wait for the merge
  mem_resp_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_resp_v_i && !mem_resp_ready_i |=> mem_resp_v_i)
    else $error("memory response dropped before ready");

  host_resp_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    host_resp_v_i && !host_resp_ready_i |=> host_resp_v_i)
    else $error("host response dropped before ready");

endmodule

bind bp_mem_bridge_top bp_mem_bridge_chk chk_inst (
  .clk_i(clk_i), .rst_i(rst_i),
  .cmd_flit_i(cmd_flit_i), .cmd_v_i(cmd_v_i), .cmd_ready_i(cmd_ready_o),
  .resp_flit_i(resp_flit_o), .resp_v_i(resp_v_o), .resp_ready_i(resp_ready_i),
  .cmd_msg_v_i(cmd_msg_v), .cmd_msg_yumi_i(cmd_msg_yumi),
  .mem_resp_v_i(mem_resp_v), .mem_resp_ready_i(mem_resp_ready),
  .host_resp_v_i(host_resp_v), .host_resp_ready_i(host_resp_ready)
);

`default_nettype wire

// ==== dv/bp_mem_bridge_tb.sv ====
/*
  Memory bridge testbench
  Directed tests over the bypass links, memory model and host MMIO
*/
`timescale 1ns/1ns
`default_nettype none

module bp_mem_bridge_tb;

  import bp_mem_bridge_pkg::*;

  localparam int clk_period_lp     = 100;
  localparam int reset_cycles_lp   = 8;
  localparam int burst_len_lp      = 8;
  localparam int num_msgs_lp       = 31;
  localparam int timeout_cycles_lp =
    num_msgs_lp * msg_flits_lp * (max_latency_lp + 8) + reset_cycles_lp + 200;
  localparam logic [paddr_width_lp-1:0] burst_base_lp = 32'h8000_0200;
  localparam logic [paddr_width_lp-1:0] single_addr_lp = 32'h8000_0040;

  logic                     clk = 1'b0;
  logic                     rst;
  logic [flit_width_lp-1:0] cmd_flit;
  logic                     cmd_v;
  logic                     cmd_ready;
  logic [flit_width_lp-1:0] resp_flit;
  logic                     resp_v;
  logic                     resp_ready;
  logic                     program_finish;

  logic [dword_width_lp-1:0] ref_mem [mem_els_lp];
  logic                      ref_finish;
  bp_mem_msg_s               exp_q [$];
  logic [31:0]               rand_state;
  string                     cur_test;
  int                        error_count;
  int                        test_errors;
  int                        tests_run;
  int                        tests_failed;

  bp_mem_bridge_top bp_mem_bridge_top_inst (
    .clk_i(clk), .rst_i(rst),
    .cmd_flit_i(cmd_flit), .cmd_v_i(cmd_v), .cmd_ready_o(cmd_ready),
    .resp_flit_o(resp_flit), .resp_v_o(resp_v), .resp_ready_i(resp_ready),
    .program_finish_o(program_finish)
  );

  always #(clk_period_lp/2) clk = ~clk;

  function automatic logic [31:0] next_rand();
    rand_state ^= rand_state << 13;
    rand_state ^= rand_state >> 17;
    rand_state ^= rand_state << 5;
    return rand_state;
  endfunction

  function automatic bp_mem_msg_s make_msg(input bp_mem_opcode_e op,
                                           input logic [paddr_width_lp-1:0] addr,
                                           input logic [dword_width_lp-1:0] data);
    bp_mem_msg_s m;
    m.opcode = op;
    m.addr   = addr;
    m.data   = data;
    return m;
  endfunction

  task automatic note_error();
    error_count++;
    test_errors++;
  endtask

  task automatic compare_msg(input string name, input bp_mem_msg_s exp, input bp_mem_msg_s act);
    if (act !== exp) begin
      $display("** Error: %s: expected op=%0d addr=%h data=%h, actual op=%0d addr=%h data=%h",
               name, exp.opcode, exp.addr, exp.data, act.opcode, act.addr, act.data);
      note_error();
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error: %s: expected finish=%b, actual finish=%b", name, exp, act);
      note_error();
    end
  endtask

  // Memory decodes on bit 31 with index addr[10:3], host echoes with zero data
  task automatic predict_resp(input bp_mem_msg_s cmd, output bp_mem_msg_s exp);
    exp = make_msg(cmd.opcode, cmd.addr, 64'h0);
    if (cmd.addr[31]) begin
      if (cmd.opcode == e_mem_wr) begin
        ref_mem[cmd.addr[10:3]] = cmd.data;
      end else begin
        exp.data = ref_mem[cmd.addr[10:3]];
      end
    end else if (cmd.addr == host_finish_addr_lp) begin
      if (cmd.opcode == e_mem_wr) begin
        ref_finish = cmd.data[0];
      end else begin
        exp.data = {63'b0, ref_finish};
      end
    end
  endtask

  // Ready is registered in the DUT, so it is stable at the falling edge
  task automatic send_msg(input bp_mem_msg_s msg);
    logic [msg_flits_lp*flit_width_lp-1:0] flits;
    flits = '0;
    flits[msg_width_lp-1:0] = msg;
    for (int i = 0; i < msg_flits_lp; i++) begin
      @(negedge clk);
      cmd_flit = flits[i*flit_width_lp +: flit_width_lp];
      cmd_v    = 1'b1;
      while (!cmd_ready) begin
        @(negedge clk);
      end
    end
    @(negedge clk);
    cmd_v = 1'b0;
  endtask

  task automatic recv_msg(input logic stall, output bp_mem_msg_s msg);
    logic [msg_flits_lp*flit_width_lp-1:0] flits;
    logic [31:0]                           rnd;
    int got;
    flits = '0;
    got   = 0;
    while (got < msg_flits_lp) begin
      @(negedge clk);
      if (stall) begin
        rnd        = next_rand();
        resp_ready = rnd[0];
      end else begin
        resp_ready = 1'b1;
      end
      if (resp_v && resp_ready) begin
        flits[got*flit_width_lp +: flit_width_lp] = resp_flit;
        got++;
      end
    end
    @(negedge clk);
    resp_ready = 1'b0;
    msg = flits[msg_width_lp-1:0];
  endtask

  task automatic issue(input bp_mem_msg_s cmd);
    bp_mem_msg_s exp;
    predict_resp(cmd, exp);
    exp_q.push_back(exp);
    send_msg(cmd);
  endtask

  task automatic drain(input int count, input logic stall);
    bp_mem_msg_s act;
    for (int i = 0; i < count; i++) begin
      recv_msg(stall, act);
      if (exp_q.size() == 0) begin
        $display("%s: a response came back with no command outstanding", cur_test);
        note_error();
      end else begin
        compare_msg(cur_test, exp_q.pop_front(), act);
      end
    end
  endtask

  task automatic transact(input bp_mem_msg_s cmd);
    issue(cmd);
    drain(1, 1'b0);
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
      $display("%s: FAILED with %0d errors", cur_test, test_errors);
    end else begin
      $display("%s: passed", cur_test);
    end
  endtask

  task automatic test_write_read();
    start_test("write_read");
    fork
      begin
        issue(make_msg(e_mem_wr, single_addr_lp, 64'hdead_beef_0123_4567));
        issue(make_msg(e_mem_rd, single_addr_lp, 64'h0));
      end
      drain(2, 1'b0);
    join
    finish_test();
  endtask

  // Sender runs alongside the receiver so several messages stay in flight
  task automatic test_burst();
    start_test("burst");
    fork
      begin
        for (int i = 0; i < burst_len_lp; i++) begin
          issue(make_msg(e_mem_wr, burst_base_lp + 32'(i * 8), {next_rand(), next_rand()}));
        end
        for (int i = 0; i < burst_len_lp; i++) begin
          issue(make_msg(e_mem_rd, burst_base_lp + 32'(i * 8), 64'h0));
        end
      end
      drain(2 * burst_len_lp, 1'b0);
    join
    finish_test();
  endtask

  task automatic test_backpressure();
    start_test("backpressure");
    fork
      begin
        for (int i = burst_len_lp - 1; i >= 0; i--) begin
          issue(make_msg(e_mem_rd, burst_base_lp + 32'(i * 8), 64'h0));
        end
      end
      drain(burst_len_lp, 1'b1);
    join
    finish_test();
  endtask

  task automatic test_finish_flag();
    start_test("finish_flag");
    compare_bit(cur_test, 1'b0, program_finish);
    transact(make_msg(e_mem_wr, host_finish_addr_lp, 64'h1));
    compare_bit(cur_test, 1'b1, program_finish);
    transact(make_msg(e_mem_rd, host_finish_addr_lp, 64'h0));
    transact(make_msg(e_mem_wr, host_finish_addr_lp, 64'h0));
    compare_bit(cur_test, 1'b0, program_finish);
    finish_test();
  endtask

  // Same low address bits on both sides of the split
  task automatic test_host_split();
    start_test("host_split");
    transact(make_msg(e_mem_rd, 32'h0000_0040, 64'h0));
    transact(make_msg(e_mem_rd, single_addr_lp, 64'h0));
    finish_test();
  endtask

  initial begin
    rst          = 1'b1;
    cmd_flit     = '0;
    cmd_v        = 1'b0;
    resp_ready   = 1'b0;
    rand_state   = 32'hf082;
    ref_finish   = 1'b0;
    cur_test     = "";
    error_count  = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (reset_cycles_lp) @(negedge clk);
    rst = 1'b0;

    test_write_read();
    test_burst();
    test_backpressure();
    test_finish_flag();
    test_host_split();

    $display("Tests run: %0d, tests failed: %0d, errors: %0d",
             tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(timeout_cycles_lp * clk_period_lp);
    $display("Watchdog expired: the run hung in test %s after %0d cycles",
             cur_test, timeout_cycles_lp);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== bp_mem_bridge.f ====
rtl/bp_mem_bridge_pkg.sv
rtl/bp_bypass_sipo.sv
rtl/bp_bypass_piso.sv
rtl/bp_io_router.sv
rtl/bp_mem_model.sv
rtl/bp_host_mmio.sv
rtl/bp_mem_bridge_top.sv
dv/bp_mem_bridge_chk.sv
dv/bp_mem_bridge_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the memory bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module bp_mem_bridge_tb \
  -f bp_mem_bridge.f \
  -o bp_mem_bridge_sim

status=0
./obj_dir/bp_mem_bridge_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Simulation failed" sim.log; then
  echo "run_sim: FAIL"
  exit 1
fi
echo "run_sim: PASS"
